/* Makefile */
VERILATOR ?= verilator
TOP ?= revo_distributor_tb
FILELIST ?= revo_distributor.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
SIM_ARGS ?= +verilator+error+limit+1000
PASS_TEXT ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "pass line not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/revo_distributor_sva.sv */
`default_nettype none

module revo_distributor_sva
	import revo_pkg::*;
(
	input logic          clock509,
	input logic          reset,
	input link_outputs_t link,
	input status_t       status
);

	logic recovered;
	logic [phase_count:0] trigger_history = '0;
	logic [word_width-1:0] start_history = '0;
	int quiet_failures = 0;
	int trigger_failures = 0;
	int word_failures = 0;
	int failures;

	assign recovered = link.clock127_out ^ link.trg_out;
	assign failures = quiet_failures + trigger_failures + word_failures;

	// bit 0 is one cycle ago
	always @(posedge clock509) begin
		trigger_history <= {trigger_history[phase_count-1:0], recovered};
		start_history <= {start_history[word_width-2:0], link.word_start};
	end

	quiet_before_ready: assert property (@(posedge clock509) disable iff (reset)
		!status.ready |-> link == '0 && !status.trg)
	else begin
		$error("link or trg active before ready");
		quiet_failures++;
	end

	// a recovered trigger run ends after exactly one ring turn
	trigger_length: assert property (@(posedge clock509) disable iff (reset)
		trigger_history[0] && !recovered |->
			trigger_history[phase_count-1:0] == '1 && !trigger_history[phase_count])
	else begin
		$error("recovered trigger high for other than one clock127 period");
		trigger_failures++;
	end

	word_spacing: assert property (@(posedge clock509) disable iff (reset)
		start_history[word_width-1] |-> link.word_start && start_history[word_width-2:0] == '0)
	else begin
		$error("word_start not spaced by one word");
		word_failures++;
	end

endmodule

bind revo_distributor revo_distributor_sva sva0 (
	.clock509 (clock509),
	.reset    (reset),
	.link     (link),
	.status   (status)
);

`default_nettype wire

/* bench/revo_distributor_tb.sv */
`default_nettype none

module revo_distributor_tb
	import revo_pkg::*;
();

	logic clock509 = 1'b0;
	logic reset;
	logic revo_in;
	logic pattern_select;
	link_outputs_t link;
	status_t status;
	logic recovered;
	int checks = 0;
	int errors = 0;
	int checks_mark = 0;
	int errors_mark = 0;
	int triggers = 0;

	revo_distributor dut0 (
		.clock509       (clock509),
		.reset          (reset),
		.revo_in        (revo_in),
		.pattern_select (pattern_select),
		.link           (link),
		.status         (status)
	);

	always #10 clock509 = ~clock509;

	// what a remote receiver decodes
	assign recovered = link.clock127_out ^ link.trg_out;

	task automatic check_int(input string name, input int got, input int expected);
		checks++;
		assert (got == expected) else begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input calibration_word_t got,
			input calibration_word_t expected);
		checks++;
		assert (got == expected) else begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic report(input int number, input string title);
		$display("test %0d %s: %0d checks, %0d errors", number, title,
			checks - checks_mark, errors - errors_mark);
		checks_mark = checks;
		errors_mark = errors;
	endtask

	task automatic idle(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clock509);
			revo_in = 1'b0;
		end
	endtask

	task automatic wait_clock_level(input logic level);
		int waited;
		waited = 0;
		while (link.clock127_out !== level && waited < 2 * phase_count) begin
			@(negedge clock509);
			waited++;
		end
		if (link.clock127_out !== level) begin
			$display("timeout waiting for clock127_out to reach %b", level);
			errors++;
		end
	endtask

	// one pulse of width cycles plus a single-cycle pulse at index second if >= 0
	task automatic pulse_check(input int width, input int second, input int window);
		logic last;
		int rises;
		int high;
		int first;
		int trg_high;
		last = recovered;
		rises = 0;
		high = 0;
		first = -1;
		trg_high = 0;
		for (int i = 0; i < window; i++) begin
			@(negedge clock509);
			revo_in = (i < width) || (i == second);
			if (recovered && !last && first < 0)
				first = i;
			if (recovered && !last)
				rises++;
			if (recovered)
				high++;
			if (status.trg)
				trg_high++;
			last = recovered;
		end
		triggers += rises;
		check_int("recovered trigger periods", rises, 1);
		check_int("recovered trigger cycles", high, phase_count);
		check_int("status.trg cycles", trg_high, phase_count);
		checks++;
		assert (first >= 0 && first <= 12) else begin
			$display("recovered trigger did not rise within 12 cycles of the pulse");
			errors++;
		end
	endtask

	task automatic read_word(output calibration_word_t word);
		int waited;
		waited = 0;
		do begin
			@(negedge clock509);
			waited++;
		end while (!link.word_start && waited < 2 * word_width);
		if (!link.word_start) begin
			$display("timeout waiting for word_start");
			errors++;
		end
		word = '0;
		for (int b = 0; b < word_width; b++) begin
			if (b > 0)
				@(negedge clock509);
			word = {word[word_width-2:0], link.serial_out};
		end
	endtask

	initial begin
		int cycles;
		int gap;
		int width;
		int spacing;
		calibration_word_t word;
		void'($urandom(32'h6f977e71));
		reset = 1'b1;
		revo_in = 1'b0;
		pattern_select = 1'b0;
		repeat (3) @(negedge clock509);
		reset = 1'b0;

		// startup hold
		cycles = 0;
		while (!status.ready && cycles < 200) begin
			@(negedge clock509);
			cycles++;
			if (!status.ready) begin
				check_int("link", int'(link), 0);
				check_int("status.trg", int'(status.trg), 0);
			end
		end
		if (!status.ready) begin
			$display("timeout waiting for status.ready");
			errors++;
		end
		check_int("cycles to status.ready", cycles, startup_cycles);
		report(1, "startup hold");

		wait_clock_level(1'b0);
		wait_clock_level(1'b1);
		for (int j = 0; j < 2 * phase_count; j++) begin
			if (j > 0)
				@(negedge clock509);
			check_int("link.clock127_out", int'(link.clock127_out), int'((j % 4) < 2));
		end
		report(2, "clock127 waveform");

		for (int k = 0; k < 6; k++) begin
			gap = 40 + $urandom % 41;
			width = 1 + $urandom % 4;
			idle(gap);
			pulse_check(width, -1, 30);
		end
		report(3, "random isolated pulses");

		// close pulse pair, then a long pulse
		spacing = 3 + $urandom % 7;
		idle(60);
		pulse_check(1, spacing, 40);
		idle(60);
		pulse_check(12, -1, 40);
		report(4, "pulse pair and long pulse");

		for (int n = 0; n < 8; n++) begin
			if (n == 4)
				pattern_select = 1'b1;
			read_word(word);
			check_word("serial word", word, (n < 4) ? calibration_word0 : calibration_word1);
			check_int("status.pattern_select", int'(status.pattern_select), int'(n >= 4));
		end
		report(5, "calibration words");

		$display("tests 5, checks %0d, errors %0d, assertion failures %0d, triggers %0d",
			checks, errors, dut0.sva0.failures, triggers);
		if (errors == 0 && dut0.sva0.failures == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* revo_distributor.f */
rtl/revo_pkg.sv
rtl/timing_generator.sv
rtl/revo_detector.sv
rtl/revo_encoder.sv
rtl/calibration_serializer.sv
rtl/revo_distributor.sv
bench/revo_distributor_sva.sv
bench/revo_distributor_tb.sv

/* rtl/calibration_serializer.sv */
`default_nettype none

module calibration_serializer
	import revo_pkg::*;
(
	input  logic clock509,
	input  logic reset,
	input  logic ready,
	input  logic pattern_select,
	output logic serial_out,
	output logic word_start
);

	localparam int bit_count_width = $clog2(word_width);

	logic [bit_count_width-1:0] bit_count;
	calibration_word_t next_word;
	calibration_word_t shift_word;
	logic boundary;

	assign boundary = (bit_count == '0);

	// word picked at each boundary
	assign next_word = pattern_select ? calibration_word1 : calibration_word0;

	// wraps every word_width cycles
	always_ff @(posedge clock509) begin
		if (reset) begin
			bit_count <= '0;
		end else if (!ready) begin
			bit_count <= '0;
		end else begin
			bit_count <= bit_count + 1'b1;
		end
	end

	// msb leaves on the load cycle and the rest shift behind it
	always_ff @(posedge clock509) begin
		if (boundary) begin
			shift_word <= {next_word[word_width-2:0], 1'b0};
		end else begin
			shift_word <= {shift_word[word_width-2:0], 1'b0};
		end
	end

	always_ff @(posedge clock509) begin
		if (reset) begin
			serial_out <= 1'b0;
			word_start <= 1'b0;
		end else if (!ready) begin
			serial_out <= 1'b0;
			word_start <= 1'b0;
		end else begin
			serial_out <= boundary ? next_word[word_width-1] : shift_word[word_width-1];
			word_start <= boundary;
		end
	end

endmodule

`default_nettype wire

/* rtl/revo_detector.sv */
`default_nettype none

module revo_detector
	import revo_pkg::*;
(
	input  logic   clock509,
	input  logic   reset,
	input  logic   revo_in,
	input  phase_t phase,
	input  logic   ready,
	output logic   trg
);

	revo_stream_t revo_stream;

	// captured parts of the stream
	logic [revo_frame-1:0] frame;
	logic [revo_quiet-1:0] quiet;

	logic first_phase;
	logic last_phase;
	logic fire;

	assign first_phase = phase[0];
	assign last_phase = phase[phase_count-1];

	// sample history, newest in bit 0
	always_ff @(posedge clock509) begin
		if (reset) begin
			revo_stream <= '0;
		end else begin
			revo_stream <= {revo_stream[revo_stream_width-2:0], revo_in};
		end
	end

	// snapshot once per ring turn
	always_ff @(posedge clock509) begin
		if (last_phase) begin
			frame <= revo_stream[revo_frame-1:0];
			quiet <= revo_stream[revo_stream_width-1:revo_frame];
		end
	end

	// activity in the newest frame after a quiet history
	assign fire = (quiet == '0) && (frame != '0);

	// trg holds for one full ring turn
	always_ff @(posedge clock509) begin
		if (reset) begin
			trg <= 1'b0;
		end else if (!ready) begin
			trg <= 1'b0;
		end else if (first_phase) begin
			trg <= fire;
		end
	end

endmodule

`default_nettype wire

/* rtl/revo_distributor.sv */
`default_nettype none

module revo_distributor
	import revo_pkg::*;
(
	input  logic          clock509,
	input  logic          reset,
	input  logic          revo_in,
	input  logic          pattern_select,
	output link_outputs_t link,
	output status_t       status
);

	phase_t phase;
	logic clock127;
	logic ready;
	logic trg;
	logic clock127_out;
	logic trg_out;
	logic serial_out;
	logic word_start;

	timing_generator timing0 (
		.clock509 (clock509),
		.reset    (reset),
		.phase    (phase),
		.clock127 (clock127),
		.ready    (ready)
	);

	revo_detector detector0 (
		.clock509 (clock509),
		.reset    (reset),
		.revo_in  (revo_in),
		.phase    (phase),
		.ready    (ready),
		.trg      (trg)
	);

	revo_encoder encoder0 (
		.clock509     (clock509),
		.reset        (reset),
		.clock127     (clock127),
		.trg          (trg),
		.ready        (ready),
		.clock127_out (clock127_out),
		.trg_out      (trg_out)
	);

	calibration_serializer serializer0 (
		.clock509       (clock509),
		.reset          (reset),
		.ready          (ready),
		.pattern_select (pattern_select),
		.serial_out     (serial_out),
		.word_start     (word_start)
	);

	// remote link
	assign link.clock127_out = clock127_out;
	assign link.trg_out = trg_out;
	assign link.serial_out = serial_out;
	assign link.word_start = word_start;

	// leds
	assign status.ready = ready;
	assign status.trg = trg;
	assign status.pattern_select = pattern_select;

endmodule

`default_nettype wire

/* rtl/revo_encoder.sv */
`default_nettype none

module revo_encoder (
	input  logic clock509,
	input  logic reset,
	input  logic clock127,
	input  logic trg,
	input  logic ready,
	output logic clock127_out,
	output logic trg_out
);

	logic encoded;

	// clock127 inverted while trg is high
	assign encoded = clock127 ^ trg;

	// both lines change on the same edge
	always_ff @(posedge clock509) begin
		if (reset) begin
			clock127_out <= 1'b0;
			trg_out <= 1'b0;
		end else if (!ready) begin
			clock127_out <= 1'b0;
			trg_out <= 1'b0;
		end else begin
			clock127_out <= clock127;
			trg_out <= encoded;
		end
	end

endmodule

`default_nettype wire

/* rtl/revo_pkg.sv */
`default_nettype none

package revo_pkg;

	// clock509 cycles per clock127 period
	localparam int phase_count = 4;

	// revolution marker stream split
	localparam int revo_frame = 4;
	localparam int revo_quiet = 12;
	localparam int revo_stream_width = revo_frame + revo_quiet;

	// cycles of quiet outputs after reset
	localparam int startup_cycles = 64;

	// calibration word length
	localparam int word_width = 8;

	// one-hot ring with bit 0 as the first phase
	typedef logic [phase_count-1:0] phase_t;

	// newest sample in bit 0
	typedef logic [revo_stream_width-1:0] revo_stream_t;

	typedef logic [word_width-1:0] calibration_word_t;

	// wide enough to hold startup_cycles itself
	typedef logic [$clog2(startup_cycles + 1)-1:0] startup_count_t;

	localparam calibration_word_t calibration_word0 = 8'b11110100;
	localparam calibration_word_t calibration_word1 = 8'b11110010;

	// lines sent to the remote side
	typedef struct packed {
		logic clock127_out;
		logic trg_out;
		logic serial_out;
		logic word_start;
	} link_outputs_t;

	// led view
	typedef struct packed {
		logic ready;
		logic trg;
		logic pattern_select;
	} status_t;

endpackage

`default_nettype wire

/* rtl/timing_generator.sv */
`default_nettype none

module timing_generator
	import revo_pkg::*;
(
	input  logic   clock509,
	input  logic   reset,
	output phase_t phase,
	output logic   clock127,
	output logic   ready
);

	localparam startup_count_t startup_last = startup_count_t'(startup_cycles - 1);
	localparam startup_count_t startup_done = startup_count_t'(startup_cycles);

	startup_count_t startup_count;

	// four-phase ring stepping once per cycle
	always_ff @(posedge clock509) begin
		if (reset) begin
			phase <= phase_t'(1);
		end else begin
			phase <= {phase[phase_count-2:0], phase[phase_count-1]};
		end
	end

	// high during the second half of the ring
	assign clock127 = |phase[phase_count-1:phase_count/2];

	// saturating startup counter
	always_ff @(posedge clock509) begin
		if (reset) begin
			startup_count <= '0;
		end else if (startup_count != startup_done) begin
			startup_count <= startup_count + 1'b1;
		end
	end

	// ready rises on the same edge the counter reaches startup_cycles
	always_ff @(posedge clock509) begin
		if (reset) begin
			ready <= 1'b0;
		end else if (startup_count == startup_last) begin
			ready <= 1'b1;
		end
	end

endmodule

`default_nettype wire
